// File: hw/ex_isa_pkg.sv
package ex_isa_pkg;

    // ==============================
    // widths
    // ==============================
    localparam int data_w    = 32;
    localparam int reg_idx_w = 5;
    localparam int ready_w   = 2;
    localparam int count_w   = $clog2(data_w) + 1;    // holds 0..32

    typedef logic [data_w-1:0]    word_t;
    typedef logic [reg_idx_w-1:0] reg_idx_t;
    typedef logic [ready_w-1:0]   ready_t;            // cycles until the value can forward

    // ==============================
    // opcodes
    // ==============================
    typedef enum logic [4:0] {
        op_nop, op_add, op_addu, op_sub, op_subu,
        op_and, op_or, op_xor, op_slt, op_sltu,
        op_sll, op_srl, op_sra, op_lui, op_addi,
        op_lb, op_lbu, op_lh, op_lhu, op_lw, op_ll,
        op_sb, op_sh, op_sw, op_sc,
        op_clo, op_clz
    } ex_op_e;

    typedef enum logic [2:0] {
        ext_none,
        ext_byte_s,
        ext_byte_u,
        ext_half_s,
        ext_half_u,
        ext_word
    } ext_type_e;

endpackage

// File: hw/ex_pipe_pkg.sv
package ex_pipe_pkg;

    import ex_isa_pkg::*;

    // ==============================
    // decode to execute
    // ==============================
    typedef struct packed {
        ex_op_e      op;
        reg_idx_t    rs_idx;
        reg_idx_t    rt_idx;
        word_t       rs_data;        // register file read
        word_t       rt_data;
        logic [4:0]  shamt;
        logic [15:0] imm16;
        reg_idx_t    dest;
        logic        wr_en;
        ready_t      ready;
    } issue_t;

    // forwarding source, used for execute and memory stage alike
    typedef struct packed {
        reg_idx_t dest;
        logic     wr_en;
        ready_t   ready;
        word_t    data;
    } fwd_t;

    typedef struct packed {
        logic      mem_read;
        logic      mem_write;
        logic [3:0] byte_en;
        ext_type_e ext;
        logic      unaligned;
    } mem_req_t;

    // ==============================
    // execute to memory
    // ==============================
    typedef struct packed {
        reg_idx_t dest;
        logic     wr_en;
        ready_t   ready;
        word_t    data;              // alu result or load/store address
        word_t    store_data;
        mem_req_t mem_req;
        logic     overflow;
        logic     link_ok;           // sc success
    } ex_result_t;

endpackage

// File: hw/operand_forward.sv
`timescale 1ns/1ps

module operand_forward import ex_isa_pkg::*; import ex_pipe_pkg::*; (
    input  reg_idx_t rs_idx,
    input  reg_idx_t rt_idx,
    input  word_t    rs_rf,
    input  word_t    rt_rf,
    input  fwd_t     ex_fwd,
    input  fwd_t     mem_fwd,
    input  logic     ex_fwd_valid,
    output word_t    rs_val,
    output word_t    rt_val
);

    // execute result first, then memory stage, then register file
    function automatic word_t select_src(input reg_idx_t idx, input word_t rf_val,
                                         input fwd_t ex_src, input logic ex_ok,
                                         input fwd_t mem_src);
        if (idx != '0 && ex_ok && ex_src.wr_en && ex_src.ready == '0 && ex_src.dest == idx)
            return ex_src.data;
        if (idx != '0 && mem_src.wr_en && mem_src.ready == '0 && mem_src.dest == idx)
            return mem_src.data;
        return rf_val;
    endfunction

    assign rs_val = select_src(rs_idx, rs_rf, ex_fwd, ex_fwd_valid, mem_fwd);
    assign rt_val = select_src(rt_idx, rt_rf, ex_fwd, ex_fwd_valid, mem_fwd);

endmodule

// File: hw/ex_alu.sv
`timescale 1ns/1ps

module ex_alu import ex_isa_pkg::*; (
    input  ex_op_e      op,
    input  word_t       a,
    input  word_t       b,
    input  logic [4:0]  shamt,
    input  logic [15:0] imm16,
    output word_t       value,
    output logic        overflow
);

    word_t simm;
    word_t sum_ab;
    word_t diff_ab;
    word_t sum_ai;

    assign simm    = {{16{imm16[15]}}, imm16};
    assign sum_ab  = a + b;
    assign diff_ab = a - b;
    assign sum_ai  = a + simm;    // addi and every load/store address

    always_comb begin
        value    = '0;
        overflow = 1'b0;
        case (op)
            op_add: begin
                value    = sum_ab;
                overflow = (a[31] == b[31]) && (sum_ab[31] != a[31]);
            end
            op_addu: value = sum_ab;
            op_sub: begin
                value    = diff_ab;
                overflow = (a[31] != b[31]) && (diff_ab[31] != a[31]);
            end
            op_subu: value = diff_ab;
            op_and:  value = a & b;
            op_or:   value = a | b;
            op_xor:  value = a ^ b;
            op_slt:  value = {{(data_w-1){1'b0}}, $signed(a) < $signed(b)};
            op_sltu: value = {{(data_w-1){1'b0}}, a < b};
            op_sll:  value = b << shamt;
            op_srl:  value = b >> shamt;
            op_sra:  value = word_t'($signed(b) >>> shamt);
            op_lui:  value = {imm16, 16'h0000};
            op_addi: begin
                value    = sum_ai;
                overflow = (a[31] == simm[31]) && (sum_ai[31] != a[31]);
            end
            op_lb, op_lbu, op_lh, op_lhu, op_lw, op_ll,
            op_sb, op_sh, op_sw, op_sc:
                value = sum_ai;
            default: value = '0;    // nop, clo and clz leave the alu idle
        endcase
    end

endmodule

// File: hw/mem_access_decode.sv
`timescale 1ns/1ps

module mem_access_decode import ex_isa_pkg::*; import ex_pipe_pkg::*; (
    input  ex_op_e     op,
    input  logic [1:0] addr_low,
    output mem_req_t   mem_req
);

    always_comb begin
        mem_req = '{mem_read: 1'b0, mem_write: 1'b0, byte_en: 4'b0000,
                    ext: ext_none, unaligned: 1'b0};
        case (op)
            op_lb, op_lbu: begin
                mem_req.mem_read = 1'b1;
                mem_req.ext      = (op == op_lb) ? ext_byte_s : ext_byte_u;
            end
            op_lh, op_lhu: begin
                mem_req.mem_read  = 1'b1;
                mem_req.ext       = (op == op_lh) ? ext_half_s : ext_half_u;
                mem_req.unaligned = addr_low[0];
            end
            op_lw, op_ll: begin
                mem_req.mem_read  = 1'b1;
                mem_req.ext       = ext_word;
                mem_req.unaligned = |addr_low;
            end
            op_sb: begin
                mem_req.mem_write = 1'b1;
                mem_req.byte_en   = 4'b0001 << addr_low;
            end
            op_sh: begin
                mem_req.mem_write = 1'b1;
                mem_req.byte_en   = 4'b0011 << addr_low;
                mem_req.unaligned = addr_low[0];
            end
            op_sw, op_sc: begin
                mem_req.mem_write = 1'b1;
                mem_req.byte_en   = 4'b1111;
                mem_req.unaligned = |addr_low;
            end
            default: ;
        endcase
        if (mem_req.unaligned)
            mem_req.byte_en = 4'b0000;    // no lane written on an alignment error
    end

endmodule

// File: hw/bit_count_unit.sv
`timescale 1ns/1ps

module bit_count_unit import ex_isa_pkg::*; (
    input  logic  Clk,
    input  logic  reset,
    input  logic  flush,
    input  logic  start,
    input  logic  count_ones,
    input  word_t operand,
    output logic  busy,
    output logic  done,
    output word_t count
);

    logic               running;
    logic               polarity;
    word_t              shreg;
    logic [count_w-1:0] cnt;
    logic               stop;

    // msb differs from the counted value, or every bit has been seen
    assign stop  = (shreg[data_w-1] != polarity) || (cnt == count_w'(data_w));
    assign busy  = running;
    assign done  = running && stop;
    assign count = {{(data_w-count_w){1'b0}}, cnt};

    always_ff @(posedge Clk) begin
        if (reset) begin
            running <= 1'b0;
        end else if (flush) begin
            running <= 1'b0;    // abandon the count
        end else if (start) begin
            running  <= 1'b1;
            polarity <= count_ones;
            shreg    <= operand;
            cnt      <= '0;
        end else if (running) begin
            if (stop) begin
                running <= 1'b0;
            end else begin
                shreg <= shreg << 1;
                cnt   <= cnt + 1'b1;
            end
        end
    end

endmodule

// File: hw/ex_result_reg.sv
`timescale 1ns/1ps

module ex_result_reg import ex_isa_pkg::*; import ex_pipe_pkg::*; (
    input  logic       Clk,
    input  logic       reset,
    input  logic       flush,
    input  logic       issue_valid,
    input  issue_t     issue,
    input  word_t      rt_val,
    input  word_t      alu_value,
    input  logic       overflow,
    input  mem_req_t   mem_req,
    input  logic       count_done,
    input  word_t      count,
    output logic       count_start,
    output logic       res_valid,
    output ex_result_t result
);

    logic     slot_full;    // a clo/clz is waiting on the count unit
    reg_idx_t slot_dest;
    logic     slot_wr_en;
    ready_t   slot_ready;
    logic     link;
    logic     accept;
    logic     is_count;
    logic     is_sc;
    ready_t   ready_dec;
    mem_req_t mem_gated;

    assign is_count    = (issue.op == op_clo) || (issue.op == op_clz);
    assign is_sc       = (issue.op == op_sc);
    assign accept      = issue_valid && !slot_full && !flush;
    assign count_start = accept && is_count;
    assign ready_dec   = (issue.ready == '0) ? '0 : issue.ready - ready_t'(1);

    // sc without a link must not reach memory
    always_comb begin
        mem_gated = mem_req;
        if (is_sc && !link) begin
            mem_gated.mem_write = 1'b0;
            mem_gated.byte_en   = 4'b0000;
        end
    end

    always_ff @(posedge Clk) begin
        if (reset) begin
            res_valid <= 1'b0;
            slot_full <= 1'b0;
            link      <= 1'b0;
        end else begin
            res_valid <= 1'b0;
            if (flush) begin
                slot_full <= 1'b0;
                result    <= '0;
            end else if (slot_full) begin
                if (count_done) begin
                    res_valid <= 1'b1;
                    slot_full <= 1'b0;
                    result    <= '{dest: slot_dest, wr_en: slot_wr_en, ready: slot_ready,
                                   data: count, store_data: '0, mem_req: '0,
                                   overflow: 1'b0, link_ok: 1'b0};
                end
            end else if (accept) begin
                if (is_count) begin
                    slot_full  <= 1'b1;
                    slot_dest  <= issue.dest;
                    slot_wr_en <= issue.wr_en;
                    slot_ready <= ready_dec;
                end else begin
                    res_valid <= 1'b1;
                    result    <= '{dest: issue.dest, wr_en: issue.wr_en, ready: ready_dec,
                                   data: alu_value, store_data: rt_val, mem_req: mem_gated,
                                   overflow: overflow, link_ok: is_sc && link};
                end
                if (issue.op == op_ll)
                    link <= 1'b1;
                else if (is_sc)
                    link <= 1'b0;
            end
        end
    end

endmodule

// File: hw/ex_stage.sv
`timescale 1ns/1ps

module ex_stage import ex_isa_pkg::*; import ex_pipe_pkg::*; (
    input  logic       Clk,
    input  logic       reset,
    input  logic       flush,
    input  logic       issue_valid,
    input  issue_t     issue,
    input  fwd_t       mem_fwd,
    output logic       res_valid,
    output ex_result_t result,
    output logic       count_busy
);

    fwd_t     ex_fwd;
    word_t    rs_val;
    word_t    rt_val;
    word_t    alu_value;
    word_t    count;
    logic     alu_overflow;
    logic     count_start;
    logic     count_done;
    mem_req_t mem_req;

    // own result register feeds back as the first forwarding source
    assign ex_fwd = '{dest: result.dest, wr_en: result.wr_en,
                      ready: result.ready, data: result.data};

    operand_forward fwd0 (
        .rs_idx      (issue.rs_idx),
        .rt_idx      (issue.rt_idx),
        .rs_rf       (issue.rs_data),
        .rt_rf       (issue.rt_data),
        .ex_fwd      (ex_fwd),
        .mem_fwd     (mem_fwd),
        .ex_fwd_valid(res_valid),
        .rs_val      (rs_val),
        .rt_val      (rt_val)
    );

    ex_alu alu0 (
        .op      (issue.op),
        .a       (rs_val),
        .b       (rt_val),
        .shamt   (issue.shamt),
        .imm16   (issue.imm16),
        .value   (alu_value),
        .overflow(alu_overflow)
    );

    mem_access_decode mdec0 (
        .op      (issue.op),
        .addr_low(alu_value[1:0]),
        .mem_req (mem_req)
    );

    bit_count_unit bcu0 (
        .Clk       (Clk),
        .reset     (reset),
        .flush     (flush),
        .start     (count_start),
        .count_ones(issue.op == op_clo),
        .operand   (rs_val),
        .busy      (count_busy),
        .done      (count_done),
        .count     (count)
    );

    ex_result_reg rreg0 (
        .Clk        (Clk),
        .reset      (reset),
        .flush      (flush),
        .issue_valid(issue_valid),
        .issue      (issue),
        .rt_val     (rt_val),
        .alu_value  (alu_value),
        .overflow   (alu_overflow),
        .mem_req    (mem_req),
        .count_done (count_done),
        .count      (count),
        .count_start(count_start),
        .res_valid  (res_valid),
        .result     (result)
    );

endmodule

// File: tests/ex_checker.sv
`timescale 1ns/1ps

module ex_checker import ex_isa_pkg::*; import ex_pipe_pkg::*; (
    input  logic       Clk,
    input  logic       reset,
    input  logic       res_valid,
    input  ex_result_t result,
    output int         pass_cnt,
    output int         fail_cnt,
    output int         checked
);

    string      name_q[$];
    ex_result_t exp_q[$];     // in issue order
    string      cur_name;
    ex_result_t cur_exp;

    task automatic add_expected(input string name, input ex_result_t exp);
        name_q.push_back(name);
        exp_q.push_back(exp);
    endtask

    // keeps only the first field that differs
    function automatic void note_mismatch(input string f, input logic [31:0] e,
                                          input logic [31:0] a, inout string field,
                                          inout logic [31:0] ev, inout logic [31:0] av);
        if (field == "" && e != a) begin
            field = f;
            ev    = e;
            av    = a;
        end
    endfunction

    function automatic bit check_result(input string name, input ex_result_t exp,
                                        input ex_result_t act);
        string       field;
        logic [31:0] ev;
        logic [31:0] av;
        field = "";
        ev    = '0;
        av    = '0;
        note_mismatch("dest", 32'(exp.dest), 32'(act.dest), field, ev, av);
        note_mismatch("wr_en", 32'(exp.wr_en), 32'(act.wr_en), field, ev, av);
        note_mismatch("ready", 32'(exp.ready), 32'(act.ready), field, ev, av);
        note_mismatch("data", exp.data, act.data, field, ev, av);
        note_mismatch("store_data", exp.store_data, act.store_data, field, ev, av);
        note_mismatch("mem_req", 32'(exp.mem_req), 32'(act.mem_req), field, ev, av);
        note_mismatch("overflow", 32'(exp.overflow), 32'(act.overflow), field, ev, av);
        note_mismatch("link_ok", 32'(exp.link_ok), 32'(act.link_ok), field, ev, av);
        if (field == "") begin
            $display("ok %s", name);
            return 1'b1;
        end
        $display("Error %s %s expected %h actual %h", name, field, ev, av);
        return 1'b0;
    endfunction

    // ==============================
    // compare on every result strobe
    // ==============================
    always @(posedge Clk) begin
        if (reset) begin
            pass_cnt <= 0;
            fail_cnt <= 0;
            checked  <= 0;
        end else if (res_valid) begin
            if (exp_q.size() == 0) begin
                $display("result strobe for dest %0d came with no test waiting", result.dest);
                fail_cnt <= fail_cnt + 1;
            end else begin
                cur_name = name_q.pop_front();
                cur_exp  = exp_q.pop_front();
                if (check_result(cur_name, cur_exp, result))
                    pass_cnt <= pass_cnt + 1;
                else
                    fail_cnt <= fail_cnt + 1;
                checked <= checked + 1;
            end
        end
    end

endmodule

// File: tests/tb_ex_stage.sv
`timescale 1ns/1ps

module tb_ex_stage import ex_isa_pkg::*; import ex_pipe_pkg::*; ();

    logic       Clk;
    logic       reset;
    logic       flush;
    logic       issue_valid;
    issue_t     issue;
    fwd_t       mem_fwd;
    logic       res_valid;
    ex_result_t result;
    logic       count_busy;
    int         chk_pass;
    int         chk_fail;
    int         chk_done;

    always #20 Clk = ~Clk;

    ex_stage dut0 (
        .Clk        (Clk),
        .reset      (reset),
        .flush      (flush),
        .issue_valid(issue_valid),
        .issue      (issue),
        .mem_fwd    (mem_fwd),
        .res_valid  (res_valid),
        .result     (result),
        .count_busy (count_busy)
    );

    ex_checker chk0 (
        .Clk      (Clk),
        .reset    (reset),
        .res_valid(res_valid),
        .result   (result),
        .pass_cnt (chk_pass),
        .fail_cnt (chk_fail),
        .checked  (chk_done)
    );

    // the result tag is one cycle closer to ready, never below zero
    function automatic ready_t ready_after(input ready_t r);
        int left;
        left = int'(r) - 1;
        if (left < 0)
            left = 0;
        return ready_t'(left);
    endfunction

    task automatic drive_idle();
        issue_valid <= 1'b0;
        flush       <= 1'b0;
        mem_fwd     <= '0;
    endtask

    task automatic wait_count_idle(output logic idle);
        int n;
        n    = 0;
        idle = 1'b0;
        while (n < 50 && !idle) begin
            @(negedge Clk);
            idle = !count_busy;
            n++;
        end
    endtask

    initial begin
        int          fd;
        int          cnt;
        int          pushed;
        int          tb_err;
        int          waited;
        logic        abort;
        logic        idle;
        logic        prev_count;
        logic        prev_flush;
        string       line;
        string       name;
        ex_op_e      op_in;
        ex_result_t  exp;
        logic [31:0] col [0:20];

        Clk         = 1'b0;
        reset       = 1'b1;
        flush       = 1'b0;
        issue_valid = 1'b0;
        issue       = '0;
        mem_fwd     = '0;
        pushed      = 0;
        tb_err      = 0;
        abort       = 1'b0;
        prev_count  = 1'b0;
        prev_flush  = 1'b0;
        repeat (4) @(posedge Clk);
        reset <= 1'b0;

        fd = $fopen("tests/ex_input.txt", "r");
        if (fd == 0) begin
            $display("could not open tests/ex_input.txt");
            abort = 1'b1;
        end

        // ==============================
        // one file line per cycle
        // ==============================
        while (!abort && $fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.substr(0, 0) == "#")
                continue;
            cnt = $sscanf(line, "%s %d %h %d %d %h %h %d %h %d %d %d %d %d %d %h %d %h %h %h %d %d",
                          name, col[0], col[1], col[2], col[3], col[4], col[5], col[6],
                          col[7], col[8], col[9], col[10], col[11], col[12], col[13],
                          col[14], col[15], col[16], col[17], col[18], col[19], col[20]);
            if (cnt != 22) begin
                $display("malformed line in tests/ex_input.txt: %s", line);
                abort = 1'b1;
                continue;
            end
            op_in = ex_op_e'(col[1][4:0]);
            if (prev_flush) begin
                @(posedge Clk);
                drive_idle();
                @(negedge Clk);
                if (count_busy) begin
                    $display("count_busy is still high one cycle after the flush");
                    tb_err++;
                end
            end
            if (col[0] == 1 && prev_count) begin
                @(posedge Clk);
                drive_idle();
                wait_count_idle(idle);
                if (!idle) begin
                    $display("timed out waiting for count_busy to fall before %s", name);
                    abort = 1'b1;
                    continue;
                end
            end
            @(posedge Clk);
            issue_valid <= (col[0] == 1);
            flush       <= (col[0] == 2);
            issue       <= '{op: op_in, rs_idx: col[2][4:0], rt_idx: col[3][4:0],
                             rs_data: col[4], rt_data: col[5], shamt: col[6][4:0],
                             imm16: col[7][15:0], dest: col[8][4:0], wr_en: col[9][0],
                             ready: col[10][1:0]};
            mem_fwd     <= '{dest: col[11][4:0], wr_en: col[12][0], ready: col[13][1:0],
                             data: col[14]};
            if (col[15] == 1) begin
                exp = '{dest: col[8][4:0], wr_en: col[9][0], ready: ready_after(col[10][1:0]),
                        data: col[16], store_data: col[17], mem_req: mem_req_t'(col[18][9:0]),
                        overflow: col[19][0], link_ok: col[20][0]};
                chk0.add_expected(name, exp);
                pushed++;
            end
            prev_count = (col[0] == 1) && (op_in inside {op_clo, op_clz});
            prev_flush = (col[0] == 2);
        end
        if (fd != 0)
            $fclose(fd);

        @(posedge Clk);
        drive_idle();
        waited = 0;
        while (!abort && chk_done < pushed && waited < 100) begin
            @(negedge Clk);
            waited++;
        end
        if (!abort && chk_done < pushed) begin
            $display("timed out with %0d results never strobed", pushed - chk_done);
            abort = 1'b1;
        end

        $display("tests: %0d passed, %0d failed, %0d other errors", chk_pass, chk_fail, tb_err);
        if (!abort && chk_fail == 0 && tb_err == 0 && chk_pass == pushed)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// File: tests/ex_input.txt
# name mode(1 issue 2 flush) op(hex ex_op_e) rs rt rs_data rt_data shamt imm16 dest wr ready
# mem_fwd dest wr ready data | expect valid data store_data mem_req(hex) overflow link_ok
add_basic   1 01 1 2 5        3        0 0000 10 1 0  0 0 0 0    1 8        3        000 0 0
add_ovf     1 01 1 2 7fffffff 1        0 0000 11 1 0  0 0 0 0    1 80000000 1        000 1 0
addu_wrap   1 02 1 2 7fffffff 1        0 0000 12 1 0  0 0 0 0    1 80000000 1        000 0 0
sub_ovf     1 03 1 2 80000000 1        0 0000 13 1 0  0 0 0 0    1 7fffffff 1        000 1 0
slt_neg     1 08 1 2 ffffffff 1        0 0000 14 1 0  0 0 0 0    1 1        1        000 0 0
sltu_big    1 09 1 2 ffffffff 1        0 0000 15 1 0  0 0 0 0    1 0        1        000 0 0
and_mask    1 05 1 2 f0f0     ff00     0 0000 16 1 0  0 0 0 0    1 f000     ff00     000 0 0
sra_neg     1 0c 1 2 0        80000000 4 0000 17 1 0  0 0 0 0    1 f8000000 80000000 000 0 0
sll_4       1 0a 1 2 0        3        4 0000 18 1 0  0 0 0 0    1 30       3        000 0 0
lui         1 0d 0 0 0        0        0 1234 19 1 0  0 0 0 0    1 12340000 0        000 0 0
fwd_src     1 02 1 2 a        14       0 0000 5  1 1  0 0 0 0    1 1e       14       000 0 0
fwd_ex      1 02 5 2 0        1        0 0000 6  1 0  5 1 0 999  1 1f       1        000 0 0
fwd_mem     1 02 7 2 0        2        0 0000 8  1 0  7 1 0 100  1 102      2        000 0 0
fwd_zero    1 02 0 2 0        3        0 0000 9  1 2  0 1 0 55   1 3        3        000 0 0
fwd_busy    1 02 9 2 4        1        0 0000 3  1 0  9 1 1 77   1 5        1        000 0 0
lw_4        1 13 1 2 1000     0        0 0004 20 1 2  0 0 0 0    1 1004     0        20a 0 0
lb_neg      1 0f 1 2 1000     0        0 fffe 21 1 2  0 0 0 0    1 ffe      0        202 0 0
lhu_2       1 12 1 2 1000     0        0 0002 22 1 2  0 0 0 0    1 1002     0        208 0 0
sb_0        1 15 1 2 1000     aa       0 0000 0  0 0  0 0 0 0    1 1000     aa       110 0 0
sb_1        1 15 1 2 1000     aa       0 0001 0  0 0  0 0 0 0    1 1001     aa       120 0 0
sb_2        1 15 1 2 1000     aa       0 0002 0  0 0  0 0 0 0    1 1002     aa       140 0 0
sb_3        1 15 1 2 1000     aa       0 0003 0  0 0  0 0 0 0    1 1003     aa       180 0 0
sh_0        1 16 1 2 1000     bb       0 0000 0  0 0  0 0 0 0    1 1000     bb       130 0 0
sh_2        1 16 1 2 1000     bb       0 0002 0  0 0  0 0 0 0    1 1002     bb       1c0 0 0
sh_odd      1 16 1 2 1000     bb       0 0001 0  0 0  0 0 0 0    1 1001     bb       101 0 0
sw_8        1 17 1 2 1000     cc       0 0008 0  0 0  0 0 0 0    1 1008     cc       1f0 0 0
lw_odd      1 13 1 2 1000     0        0 0002 23 1 2  0 0 0 0    1 1002     0        20b 0 0
ll          1 14 1 2 1000     0        0 0000 24 1 2  0 0 0 0    1 1000     0        20a 0 0
sc_ok       1 18 1 2 1000     5        0 0000 0  0 0  0 0 0 0    1 1000     5        1f0 0 1
sc_fail     1 18 1 2 1000     5        0 0000 0  0 0  0 0 0 0    1 1000     5        000 0 0
clo_16      1 19 1 2 ffff0000 0        0 0000 25 1 0  0 0 0 0    1 10       0        000 0 0
clo_ones    1 19 1 2 ffffffff 0        0 0000 26 1 0  0 0 0 0    1 20       0        000 0 0
clz_zero    1 1a 1 2 0        0        0 0000 27 1 0  0 0 0 0    1 20       0        000 0 0
clz_msb     1 1a 1 2 80000000 0        0 0000 28 1 0  0 0 0 0    1 0        0        000 0 0
clz_4       1 1a 1 2 0fffffff 0        0 0000 29 1 0  0 0 0 0    1 4        0        000 0 0
clo_flushed 1 19 1 2 ffff0000 0        0 0000 30 1 0  0 0 0 0    0 0        0        000 0 0
flush       2 00 0 0 0        0        0 0000 0  0 0  0 0 0 0    0 0        0        000 0 0
after_flush 1 02 1 2 2        3        0 0000 31 1 0  0 0 0 0    1 5        3        000 0 0

// File: vlog.f
hw/ex_isa_pkg.sv
hw/ex_pipe_pkg.sv
hw/operand_forward.sv
hw/ex_alu.sv
hw/mem_access_decode.sv
hw/bit_count_unit.sv
hw/ex_result_reg.sv
hw/ex_stage.sv
tests/ex_checker.sv
tests/tb_ex_stage.sv

// File: run_sim.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/1ps --top-module tb_ex_stage -f vlog.f \
    > build.log 2>&1 && ./obj_dir/Vtb_ex_stage > sim.log 2>&1
grep -q "Test passed" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
